// File: rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define ADDR_W        16
`define INSTR_W       24
`define OPC_W         8

// Instruction fields
`define OPC_HI        23
`define OPC_LO        16
`define TGT_GP_HI     15
`define TGT_GP_LO     12
`define TGT_GP_SZ     4
`define CC_HI         15   // Shares bits with tgt_gp
`define CC_LO         12
`define CC_SZ         4
`define SRC_GP_HI     11
`define SRC_GP_LO     8
`define SRC_GP_SZ     4
`define IMM_HI        11
`define IMM_LO        0
`define IMM_SZ        12
`define TGT_SR_HI     13
`define TGT_SR_LO     12
`define TGT_SR_SZ     2
`define SRC_SR_HI     9
`define SRC_SR_LO     8
`define SRC_SR_SZ     2
`define IMMSR_HI      7
`define IMMSR_LO      0
`define IMMSR_SZ      8

`define QUEUE_DEPTH   4    // Power of two
`define QUEUE_AW      2

`endif

// File: rtl/isa_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package isa_pkg;

    // Reduced opcode set, anything else decodes as NOP
    typedef enum logic [`OPC_W-1:0] {
        NOP      = 8'h00,
        R_MOV    = 8'h01,
        R_ADD    = 8'h02,
        R_SUB    = 8'h03,
        R_AND    = 8'h04,
        R_CMP    = 8'h05,
        R_JCC    = 8'h06,
        R_LD     = 8'h07,
        R_ST     = 8'h08,
        RS_ADDs  = 8'h09,
        I_MOVi   = 8'h0a,
        I_ADDi   = 8'h0b,
        I_CMPi   = 8'h0c,
        IS_BCCis = 8'h0d,
        S_SRMOV  = 8'h0e,
        S_SRJCC  = 8'h0f
    } opcode_e;

    // Per-opcode class flags, drives field gating
    typedef struct packed {
        logic sgn_en;
        logic imm_en;
        logic is_branch;
        logic tgt_gp_we;
        logic has_tgt_gp;
        logic tgt_sr_we;   // Also marks tgt_sr present
        logic has_src_gp;
        logic has_src_sr;
        logic has_immsr;
    } dec_flags_t;

endpackage

`default_nettype wire

// File: rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef enum logic [1:0] {
        F_IDLE = 2'd0,   // Waiting for queue space
        F_REQ  = 2'd1    // Strobe held until ack
    } fetch_state_e;

endpackage

`default_nettype wire

// File: rtl/if_fetch.sv
`default_nettype none

`include "cpu_macros.svh"

module if_fetch (
    input  logic                iw_clk,
    input  logic                iw_rst,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic [`ADDR_W-1:0]  wb_adr,
    input  logic [`INSTR_W-1:0] wb_dat,
    input  logic                wb_ack,
    input  logic                q_full,
    output logic                push,
    output logic [`ADDR_W-1:0]  push_pc,
    output logic [`INSTR_W-1:0] push_instr
);

    bus_pkg::fetch_state_e state;
    logic [`ADDR_W-1:0]    pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state <= bus_pkg::F_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                bus_pkg::F_IDLE: begin
                    // Push only fires in F_REQ, so none is pending here
                    if (!q_full) begin
                        state <= bus_pkg::F_REQ;
                    end
                end
                bus_pkg::F_REQ: begin
                    if (wb_ack) begin
                        state <= bus_pkg::F_IDLE;   // Bus idles at least one cycle
                        pc    <= pc + `ADDR_W'(1);
                    end
                end
                default: begin
                    state <= bus_pkg::F_IDLE;
                end
            endcase
        end
    end

    // Cycle and strobe share the state bit
    assign wb_cyc = (state == bus_pkg::F_REQ);
    assign wb_stb = wb_cyc;
    assign wb_adr = pc;          // Stable while waiting

    // Word goes straight into the queue on ack
    assign push       = wb_cyc && wb_ack;
    assign push_pc    = pc;
    assign push_instr = wb_dat;

endmodule

`default_nettype wire

// File: rtl/instr_queue.sv
`default_nettype none

`include "cpu_macros.svh"

module instr_queue (
    input  logic                iw_clk,
    input  logic                iw_rst,
    input  logic                push,
    input  logic [`ADDR_W-1:0]  push_pc,
    input  logic [`INSTR_W-1:0] push_instr,
    input  logic                pending,
    output logic                full,
    input  logic                pop,
    output logic                empty,
    output logic [`ADDR_W-1:0]  head_pc,
    output logic [`INSTR_W-1:0] head_instr
);

    localparam logic [`QUEUE_AW:0] DEPTH_C = (`QUEUE_AW+1)'(`QUEUE_DEPTH);

    logic [`ADDR_W-1:0]  pc_mem    [`QUEUE_DEPTH];
    logic [`INSTR_W-1:0] instr_mem [`QUEUE_DEPTH];
    logic [`QUEUE_AW-1:0] wr_ptr;
    logic [`QUEUE_AW-1:0] rd_ptr;
    logic [`QUEUE_AW:0]   count;
    logic                 do_pop;

    assign do_pop = pop && !empty;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;       // Pointers wrap
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge iw_clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= push_pc;
            instr_mem[wr_ptr] <= push_instr;
        end
    end

    // Outstanding bus cycle holds one slot
    assign full  = (count + {`QUEUE_AW'b0, pending}) >= DEPTH_C;
    assign empty = (count == '0);

    assign head_pc    = pc_mem[rd_ptr];   // Fall-through head
    assign head_instr = instr_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/id_decode.sv
`default_nettype none

`include "cpu_macros.svh"

module id_decode (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  logic                  q_empty,
    input  logic [`ADDR_W-1:0]    q_pc,
    input  logic [`INSTR_W-1:0]   q_instr,
    output logic                  pop,
    input  logic                  id_ready,
    output logic                  id_valid,
    output logic [`ADDR_W-1:0]    id_pc,
    output logic [`INSTR_W-1:0]   id_instr,
    output isa_pkg::opcode_e      id_opc,
    output logic                  id_sgn_en,
    output logic                  id_imm_en,
    output logic [`IMM_SZ-1:0]    id_imm_val,
    output logic [`IMMSR_SZ-1:0]  id_immsr_val,
    output logic [`CC_SZ-1:0]     id_cc,
    output logic [`TGT_GP_SZ-1:0] id_tgt_gp,
    output logic                  id_tgt_gp_we,
    output logic [`TGT_SR_SZ-1:0] id_tgt_sr,
    output logic                  id_tgt_sr_we,
    output logic [`SRC_GP_SZ-1:0] id_src_gp,
    output logic [`SRC_SR_SZ-1:0] id_src_sr
);

    isa_pkg::opcode_e    opc;
    isa_pkg::dec_flags_t fl;
    logic                load;

    // Raw code kept even when it is not in the enum
    assign opc = isa_pkg::opcode_e'(q_instr[`OPC_HI:`OPC_LO]);

    always_comb begin
        fl = '0;
        case (opc)
            isa_pkg::R_MOV, isa_pkg::R_ADD, isa_pkg::R_SUB, isa_pkg::R_AND: begin
                fl.tgt_gp_we  = 1'b1;
                fl.has_tgt_gp = 1'b1;
                fl.has_src_gp = 1'b1;
            end
            isa_pkg::R_CMP: begin
                fl.has_tgt_gp = 1'b1;
                fl.has_src_gp = 1'b1;
            end
            isa_pkg::R_JCC: begin
                fl.is_branch  = 1'b1;
                fl.has_src_gp = 1'b1;
            end
            isa_pkg::R_LD: begin
                fl.tgt_gp_we  = 1'b1;
                fl.has_tgt_gp = 1'b1;
            end
            isa_pkg::R_ST: fl.has_src_gp = 1'b1;
            isa_pkg::RS_ADDs: begin
                fl.sgn_en     = 1'b1;
                fl.tgt_gp_we  = 1'b1;
                fl.has_tgt_gp = 1'b1;
                fl.has_src_gp = 1'b1;
            end
            isa_pkg::I_MOVi, isa_pkg::I_ADDi: begin
                fl.imm_en     = 1'b1;
                fl.tgt_gp_we  = 1'b1;
                fl.has_tgt_gp = 1'b1;
            end
            isa_pkg::I_CMPi: begin
                fl.imm_en     = 1'b1;
                fl.has_tgt_gp = 1'b1;
            end
            isa_pkg::IS_BCCis: begin
                fl.sgn_en    = 1'b1;
                fl.imm_en    = 1'b1;
                fl.is_branch = 1'b1;
            end
            isa_pkg::S_SRMOV: begin
                fl.tgt_sr_we  = 1'b1;
                fl.has_src_sr = 1'b1;
            end
            isa_pkg::S_SRJCC: begin
                fl.is_branch  = 1'b1;
                fl.has_src_sr = 1'b1;
                fl.has_immsr  = 1'b1;
            end
            default: fl = '0;   // NOP and unknown codes
        endcase
    end

    // Take a new entry when empty or when the current one leaves
    assign load = !q_empty && (!id_valid || id_ready);
    assign pop  = load;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            id_valid <= 1'b0;
        end else if (load) begin
            id_valid <= 1'b1;
        end else if (id_ready) begin
            id_valid <= 1'b0;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (load) begin
            id_pc        <= q_pc;
            id_instr     <= q_instr;
            id_opc       <= opc;
            id_sgn_en    <= fl.sgn_en;
            id_imm_en    <= fl.imm_en;
            id_imm_val   <= fl.imm_en ? q_instr[`IMM_HI:`IMM_LO] : '0;
            id_immsr_val <= fl.has_immsr ? q_instr[`IMMSR_HI:`IMMSR_LO] : '0;
            id_cc        <= fl.is_branch ? q_instr[`CC_HI:`CC_LO] : '0;
            id_tgt_gp    <= fl.has_tgt_gp ? q_instr[`TGT_GP_HI:`TGT_GP_LO] : '0;
            id_tgt_gp_we <= fl.tgt_gp_we;
            id_tgt_sr    <= fl.tgt_sr_we ? q_instr[`TGT_SR_HI:`TGT_SR_LO] : '0;
            id_tgt_sr_we <= fl.tgt_sr_we;
            id_src_gp    <= fl.has_src_gp ? q_instr[`SRC_GP_HI:`SRC_GP_LO] : '0;
            id_src_sr    <= fl.has_src_sr ? q_instr[`SRC_SR_HI:`SRC_SR_LO] : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/frontend_top.sv
`default_nettype none

`include "cpu_macros.svh"

module frontend_top (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [`ADDR_W-1:0]    wb_adr,
    input  logic [`INSTR_W-1:0]   wb_dat,
    input  logic                  wb_ack,
    input  logic                  id_ready,
    output logic                  id_valid,
    output logic [`ADDR_W-1:0]    id_pc,
    output logic [`INSTR_W-1:0]   id_instr,
    output isa_pkg::opcode_e      id_opc,
    output logic                  id_sgn_en,
    output logic                  id_imm_en,
    output logic [`IMM_SZ-1:0]    id_imm_val,
    output logic [`IMMSR_SZ-1:0]  id_immsr_val,
    output logic [`CC_SZ-1:0]     id_cc,
    output logic [`TGT_GP_SZ-1:0] id_tgt_gp,
    output logic                  id_tgt_gp_we,
    output logic [`TGT_SR_SZ-1:0] id_tgt_sr,
    output logic                  id_tgt_sr_we,
    output logic [`SRC_GP_SZ-1:0] id_src_gp,
    output logic [`SRC_SR_SZ-1:0] id_src_sr
);

    logic                push;
    logic [`ADDR_W-1:0]  push_pc;
    logic [`INSTR_W-1:0] push_instr;
    logic                q_full;
    logic                pop;
    logic                q_empty;
    logic [`ADDR_W-1:0]  head_pc;
    logic [`INSTR_W-1:0] head_instr;

    if_fetch u_fetch (
        .iw_clk(iw_clk), .iw_rst(iw_rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat(wb_dat), .wb_ack(wb_ack),
        .q_full(q_full),
        .push(push), .push_pc(push_pc), .push_instr(push_instr)
    );

    // Open bus cycle reserves a queue slot
    instr_queue u_queue (
        .iw_clk(iw_clk), .iw_rst(iw_rst),
        .push(push), .push_pc(push_pc), .push_instr(push_instr),
        .pending(wb_cyc), .full(q_full),
        .pop(pop), .empty(q_empty),
        .head_pc(head_pc), .head_instr(head_instr)
    );

    id_decode u_decode (
        .iw_clk(iw_clk), .iw_rst(iw_rst),
        .q_empty(q_empty), .q_pc(head_pc), .q_instr(head_instr),
        .pop(pop), .id_ready(id_ready), .id_valid(id_valid),
        .id_pc(id_pc), .id_instr(id_instr), .id_opc(id_opc),
        .id_sgn_en(id_sgn_en), .id_imm_en(id_imm_en),
        .id_imm_val(id_imm_val), .id_immsr_val(id_immsr_val), .id_cc(id_cc),
        .id_tgt_gp(id_tgt_gp), .id_tgt_gp_we(id_tgt_gp_we),
        .id_tgt_sr(id_tgt_sr), .id_tgt_sr_we(id_tgt_sr_we),
        .id_src_gp(id_src_gp), .id_src_sr(id_src_sr)
    );

endmodule

`default_nettype wire

// File: sim/frontend_asserts.sv
`default_nettype none

`include "cpu_macros.svh"

module frontend_asserts (
    input logic                iw_clk,
    input logic                iw_rst,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic [`ADDR_W-1:0]  wb_adr,
    input logic                wb_ack,
    input logic                q_full,
    input logic                id_valid,
    input logic                id_ready,
    input logic [`ADDR_W-1:0]  id_pc,
    input logic [`INSTR_W-1:0] id_instr,
    input isa_pkg::opcode_e    id_opc
);

    adr_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("Wishbone address or strobe changed before ack");

    cyc_drop: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (wb_cyc && wb_ack) |=> !wb_cyc)
        else $error("Wishbone cycle did not end after ack");

    full_idle: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (q_full && !wb_cyc) |=> !wb_cyc)   // No new cycle into a full queue
        else $error("Fetch started a cycle with the queue full");

    out_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (id_valid && !id_ready) |=>
            (id_valid && $stable(id_pc) && $stable(id_instr) && $stable(id_opc)))
        else $error("Decode outputs changed under back-pressure");

endmodule

bind frontend_top frontend_asserts u_asserts (
    .iw_clk(iw_clk), .iw_rst(iw_rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_ack(wb_ack),
    .q_full(q_full),
    .id_valid(id_valid), .id_ready(id_ready),
    .id_pc(id_pc), .id_instr(id_instr), .id_opc(id_opc)
);

`default_nettype wire

// File: sim/frontend_tb.sv
`default_nettype none

`include "cpu_macros.svh"

module frontend_tb;

    localparam int NUM_WORDS    = 64;
    localparam int STALL_CYCLES = 8;
    localparam int WATCHDOG_T   = NUM_WORDS * 10 * 8 + STALL_CYCLES * 8 + 2000;

    typedef struct packed {
        isa_pkg::opcode_e      opc;
        logic                  sgn_en;
        logic                  imm_en;
        logic [`IMM_SZ-1:0]    imm_val;
        logic [`IMMSR_SZ-1:0]  immsr_val;
        logic [`CC_SZ-1:0]     cc;
        logic [`TGT_GP_SZ-1:0] tgt_gp;
        logic                  tgt_gp_we;
        logic [`TGT_SR_SZ-1:0] tgt_sr;
        logic                  tgt_sr_we;
        logic [`SRC_GP_SZ-1:0] src_gp;
        logic [`SRC_SR_SZ-1:0] src_sr;
    } dec_exp_t;

    logic                  iw_clk;
    logic                  iw_rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [`ADDR_W-1:0]    wb_adr;
    logic [`INSTR_W-1:0]   wb_dat;
    logic                  wb_ack;
    logic                  id_ready;
    logic                  id_valid;
    logic [`ADDR_W-1:0]    id_pc;
    logic [`INSTR_W-1:0]   id_instr;
    isa_pkg::opcode_e      id_opc;
    logic                  id_sgn_en;
    logic                  id_imm_en;
    logic [`IMM_SZ-1:0]    id_imm_val;
    logic [`IMMSR_SZ-1:0]  id_immsr_val;
    logic [`CC_SZ-1:0]     id_cc;
    logic [`TGT_GP_SZ-1:0] id_tgt_gp;
    logic                  id_tgt_gp_we;
    logic [`TGT_SR_SZ-1:0] id_tgt_sr;
    logic                  id_tgt_sr_we;
    logic [`SRC_GP_SZ-1:0] id_src_gp;
    logic [`SRC_SR_SZ-1:0] id_src_sr;

    logic [`INSTR_W-1:0] mem [NUM_WORDS];
    logic [31:0]         bus_rng;
    logic [31:0]         rdy_rng;
    int                  xfer_cnt = 0;
    int                  ack_cnt = 0;

    frontend_top uut (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic dec_exp_t decode_ref(input logic [`INSTR_W-1:0] w);
        dec_exp_t         e;
        isa_pkg::opcode_e op;
        logic             br;
        logic             has_tgt;
        logic             has_src;
        logic             has_ssr;
        logic             has_isr;
        op = isa_pkg::opcode_e'(w[`OPC_HI:`OPC_LO]);
        e = '0;
        e.opc       = op;
        e.sgn_en    = op inside {isa_pkg::RS_ADDs, isa_pkg::IS_BCCis};
        e.imm_en    = op inside {isa_pkg::I_MOVi, isa_pkg::I_ADDi, isa_pkg::I_CMPi,
                                 isa_pkg::IS_BCCis};
        br          = op inside {isa_pkg::R_JCC, isa_pkg::IS_BCCis, isa_pkg::S_SRJCC};
        e.tgt_gp_we = op inside {isa_pkg::R_MOV, isa_pkg::R_ADD, isa_pkg::R_SUB,
                                 isa_pkg::R_AND, isa_pkg::R_LD, isa_pkg::RS_ADDs,
                                 isa_pkg::I_MOVi, isa_pkg::I_ADDi};
        has_tgt     = e.tgt_gp_we || (op inside {isa_pkg::R_CMP, isa_pkg::I_CMPi});
        has_src     = op inside {isa_pkg::R_MOV, isa_pkg::R_ADD, isa_pkg::R_SUB,
                                 isa_pkg::R_AND, isa_pkg::R_CMP, isa_pkg::R_JCC,
                                 isa_pkg::R_ST, isa_pkg::RS_ADDs};
        e.tgt_sr_we = (op == isa_pkg::S_SRMOV);
        has_ssr     = op inside {isa_pkg::S_SRMOV, isa_pkg::S_SRJCC};
        has_isr     = (op == isa_pkg::S_SRJCC);
        e.imm_val   = e.imm_en ? w[`IMM_HI:`IMM_LO] : '0;
        e.immsr_val = has_isr ? w[`IMMSR_HI:`IMMSR_LO] : '0;
        e.cc        = br ? w[`CC_HI:`CC_LO] : '0;
        e.tgt_gp    = has_tgt ? w[`TGT_GP_HI:`TGT_GP_LO] : '0;
        e.tgt_sr    = e.tgt_sr_we ? w[`TGT_SR_HI:`TGT_SR_LO] : '0;
        e.src_gp    = has_src ? w[`SRC_GP_HI:`SRC_GP_LO] : '0;
        e.src_sr    = has_ssr ? w[`SRC_SR_HI:`SRC_SR_LO] : '0;
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_opc(string test, isa_pkg::opcode_e exp, isa_pkg::opcode_e act);
        if (exp !== act) begin
            $display("Mismatch %s opc expected %h actual %h", test, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_field(string test, string what, logic [`INSTR_W-1:0] exp,
                               logic [`INSTR_W-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s %s expected %h actual %h", test, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(string test, string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Mismatch %s %s expected %b actual %b", test, what, exp, act);
            stop_with_failure();
        end
    endtask

    initial begin
        iw_clk = 1'b0;
        forever #4 iw_clk = ~iw_clk;
    end

    initial begin : main_seq
        logic [31:0] rng;
        logic [31:0] r;
        iw_rst   = 1'b1;
        wb_dat   = '0;
        wb_ack   = 1'b0;
        id_ready = 1'b0;
        rng      = 32'hed74;
        // Two passes over all 16 opcodes, then mostly unknown codes
        for (int i = 0; i < NUM_WORDS; i++) begin
            draw_bits(rng, `INSTR_W, r);
            if (i < 32) mem[i] = {8'(i % 16), r[15:0]};
            else mem[i] = r[`INSTR_W-1:0];
        end
        bus_rng = rng;
        draw_bits(rng, 32, r);
        rdy_rng = rng;
        repeat (5) @(negedge iw_clk);
        iw_rst = 1'b0;
        wait (xfer_cnt == NUM_WORDS);
        $display("TEST OK");
        $finish;
    end

    initial begin : bus_model
        logic [31:0] w;
        forever begin
            @(negedge iw_clk);
            if (wb_cyc && wb_stb) begin
                draw_bits(bus_rng, 2, w);
                repeat (w[1:0]) @(negedge iw_clk);   // Wait states
                wb_dat = mem[wb_adr[5:0]];
                wb_ack = 1'b1;
                @(negedge iw_clk);
                wb_ack = 1'b0;
            end
        end
    end

    // Words accepted by the fetch unit
    always @(posedge iw_clk) begin : ack_count
        if (!iw_rst && wb_cyc && wb_ack) begin
            ack_cnt = ack_cnt + 1;
        end
    end

    initial begin : ready_driver
        logic [31:0] r;
        wait (!iw_rst);
        wait (ack_cnt == `QUEUE_DEPTH + 1);         // Queue plus decode register
        repeat (STALL_CYCLES) @(negedge iw_clk);    // Fetch has to stay idle
        check_flag("back-pressure", "wb_cyc", 1'b0, wb_cyc);
        check_field("back-pressure", "acks", `INSTR_W'(`QUEUE_DEPTH + 1),
                    `INSTR_W'(ack_cnt));
        check_flag("back-pressure", "id_valid", 1'b1, id_valid);
        check_field("back-pressure", "id_pc", '0, `INSTR_W'(id_pc));
        id_ready = 1'b1;
        forever begin
            @(negedge iw_clk);
            draw_bits(rdy_rng, 4, r);
            if (r[3:2] == 2'b00) begin
                id_ready = 1'b0;
                repeat (r[1:0]) @(negedge iw_clk);
            end
            id_ready = 1'b1;
        end
    end

    always @(posedge iw_clk) begin : compare
        dec_exp_t e;
        string    t;
        if (!iw_rst && id_valid && id_ready && xfer_cnt < NUM_WORDS) begin
            e = decode_ref(mem[xfer_cnt[5:0]]);
            t = $sformatf("word %0d", xfer_cnt);
            check_field(t, "pc", `INSTR_W'(xfer_cnt), `INSTR_W'(id_pc));
            check_field(t, "instr", mem[xfer_cnt[5:0]], id_instr);
            check_opc(t, e.opc, id_opc);
            check_flag(t, "sgn_en", e.sgn_en, id_sgn_en);
            check_flag(t, "imm_en", e.imm_en, id_imm_en);
            check_field(t, "imm_val", `INSTR_W'(e.imm_val), `INSTR_W'(id_imm_val));
            check_field(t, "immsr_val", `INSTR_W'(e.immsr_val), `INSTR_W'(id_immsr_val));
            check_field(t, "cc", `INSTR_W'(e.cc), `INSTR_W'(id_cc));
            check_field(t, "tgt_gp", `INSTR_W'(e.tgt_gp), `INSTR_W'(id_tgt_gp));
            check_flag(t, "tgt_gp_we", e.tgt_gp_we, id_tgt_gp_we);
            check_field(t, "tgt_sr", `INSTR_W'(e.tgt_sr), `INSTR_W'(id_tgt_sr));
            check_flag(t, "tgt_sr_we", e.tgt_sr_we, id_tgt_sr_we);
            check_field(t, "src_gp", `INSTR_W'(e.src_gp), `INSTR_W'(id_src_gp));
            check_field(t, "src_sr", `INSTR_W'(e.src_sr), `INSTR_W'(id_src_sr));
            xfer_cnt = xfer_cnt + 1;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("Pipeline stalled, only %0d of %0d words decoded", xfer_cnt, NUM_WORDS);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/if_fetch.sv
rtl/instr_queue.sv
rtl/id_decode.sv
rtl/frontend_top.sv
sim/frontend_asserts.sv
sim/frontend_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module frontend_tb -o frontend_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/frontend_sim 2>&1)
echo "$out"
echo "$out" | grep -q "TEST OK" && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
